//--- bench/fpu_stim.txt
# op inst fs_val ft_val gpr_val exp_fpr exp_gpr exp_exc, all hex, one op per line
# exp_exc bits: unimpl invalid divided_by_zero overflow underflow inexact
1 00000000 40490fdb 00000000 00000000 40490fdb 00000000 00
2 00000000 00000000 00000000 12345678 12345678 00000000 00
3 00000000 00000000 c0000000 00000000 00000000 c0000000 00
4 00000000 3f800000 00000000 00000000 bf800000 00000000 00
5 00000000 c0200000 00000000 00000000 40200000 00000000 00
4 00000000 7fffffff 00000000 00000000 7fffffff 00000000 10
5 00000000 7fbfffff 00000000 00000000 7fbfffff 00000000 10
6 00000000 7fc00000 3f800000 00000000 00000000 00000000 00
6 00000101 7fc00000 3f800000 00000000 00000000 00000000 00
6 00000202 00000000 80000000 00000000 00000000 00000000 00
6 00000303 3f800000 40000000 00000000 00000000 00000000 00
6 00000404 3f800000 40000000 00000000 00000000 00000000 00
6 00000505 40000000 3f800000 00000000 00000000 00000000 00
6 00000606 3f800000 3f800000 00000000 00000000 00000000 00
6 00000707 7fc00000 3f800000 00000000 00000000 00000000 00
d 0000c800 00000000 00000000 00000000 00000000 000000d6 00
7 00000000 40200000 00000000 00000000 00000002 00000000 00
8 00000000 40200000 00000000 00000000 00000002 00000000 00
8 00000000 40600000 00000000 00000000 00000004 00000000 00
9 00000000 c0200000 00000000 00000000 fffffffe 00000000 00
a 00000000 c0200000 00000000 00000000 fffffffd 00000000 00
9 00000000 3fa00000 00000000 00000000 00000002 00000000 00
7 00000000 4f32d05e 00000000 00000000 7fffffff 00000000 10
a 00000000 bf000000 00000000 00000000 ffffffff 00000000 00
d 0000d000 00000000 00000000 00000000 00000000 00000040 00
8 00000000 7fc00000 00000000 00000000 7fffffff 00000000 10
d 0000d000 00000000 00000000 00000000 00000000 00010040 00
c 0000e000 00000000 00000000 00000f86 00000000 00000000 00
b 00000000 40200000 00000000 00000000 00000003 00000000 00
d 0000e000 00000000 00000000 00000000 00000000 00000f86 00
e 00000000 3f800000 00000000 00000000 00000000 00000000 20
c 0000f800 00000000 00000000 81830a5d 00000000 00000000 00
d 0000f800 00000000 00000000 00000000 00000000 81830a5d 00
b 00000000 40600000 00000000 00000000 00000003 00000000 00

//--- compile.f
+incdir+rtl
rtl/fpu_op_pkg.sv
rtl/fcsr_pkg.sv
rtl/fp_compare.sv
rtl/fp_to_int.sv
rtl/fcsr_regs.sv
rtl/fpu_ex.sv
rtl/fpu_top.sv
bench/tb_clock.sv
bench/fpu_checker.sv
bench/tb_fpu.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_fpu
FILELIST = compile.f

BIN      = obj_dir/V$(TOP)
SOURCES  = $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: run clean

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qxF '*** PASSED ***'

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- bench/tb_fpu.sv
`default_nettype none

module tb_fpu
	import fpu_op_pkg::*, fcsr_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

typedef struct packed {
	fpu_op_t    op;
	word_t      inst;
	word_t      fs_val;
	word_t      ft_val;
	word_t      gpr_val;
	word_t      exp_fpr;
	word_t      exp_gpr;
	logic [5:0] exp_exc;
} stim_t;

logic        clk;
logic        arst_n;
logic        issue;
fpu_op_t     op;
word_t       inst;
word_t       fs_val;
word_t       ft_val;
word_t       gpr_val;
word_t       exp_fpr;
word_t       exp_gpr;
logic [5:0]  exp_exc;
logic        done;
logic        fpr_we;
logic        gpr_we;
logic        busy;
word_t       fpr_wdata;
word_t       gpr_wdata;
fpu_except_t except;
int          pass_cnt;
int          fail_cnt;
int          cycles;
int          cycle_limit = 0;
stim_t       stim_q[$];

tb_clock #(.period_ns(10), .reset_cycles(3)) clock_i(.clk, .arst_n);

fpu_top dut_i(
	.clk, .arst_n, .issue, .op, .inst, .fs_val, .ft_val, .gpr_val,
	.done, .fpr_we, .fpr_wdata, .gpr_we, .gpr_wdata, .except, .busy
);

fpu_checker checker_i(
	.clk, .issue, .busy, .op, .exp_fpr, .exp_gpr, .exp_exc,
	.done, .fpr_we, .fpr_wdata, .gpr_we, .gpr_wdata, .except,
	.pass_cnt, .fail_cnt
);

task automatic load_stim(output logic ok);
	int          fd;
	string       line;
	stim_t       s;
	logic [31:0] f_op, f_inst, f_fs, f_ft, f_gpr, f_fpr, f_gprx, f_exc;
	ok = 1'b0;
	fd = $fopen("bench/fpu_stim.txt", "r");
	if(fd != 0)
	begin
		while($fgets(line, fd) != 0)
		begin
			// comment lines give no fields
			if($sscanf(line, "%h %h %h %h %h %h %h %h", f_op, f_inst, f_fs, f_ft,
				f_gpr, f_fpr, f_gprx, f_exc) == 8)
			begin
				s.op      = fpu_op_t'(f_op[4:0]);
				s.inst    = f_inst;
				s.fs_val  = f_fs;
				s.ft_val  = f_ft;
				s.gpr_val = f_gpr;
				s.exp_fpr = f_fpr;
				s.exp_gpr = f_gprx;
				s.exp_exc = f_exc[5:0];
				stim_q.push_back(s);
			end
		end
		$fclose(fd);
		ok = stim_q.size() > 0;
	end
endtask

// called on the negedge, returns on the negedge after done
task automatic run_op(input stim_t s, input int k);
	issue   = 1'b1;
	op      = s.op;
	inst    = s.inst;
	fs_val  = s.fs_val;
	ft_val  = s.ft_val;
	gpr_val = s.gpr_val;
	exp_fpr = s.exp_fpr;
	exp_gpr = s.exp_gpr;
	exp_exc = s.exp_exc;
	@(negedge clk);
	issue = 1'b0;
	while(!done && (pass_cnt + fail_cnt) <= k)
		@(negedge clk);
endtask

task automatic end_run(input logic aborted);
	$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
	if(aborted || fail_cnt != 0)
		$display("*** FAILED ***");
	else
		$display("*** PASSED ***");
	$finish;
endtask

initial
begin
	logic ok;
	issue   = 1'b0;
	op      = FPU_OP_NOP;
	inst    = '0;
	fs_val  = '0;
	ft_val  = '0;
	gpr_val = '0;
	exp_fpr = '0;
	exp_gpr = '0;
	exp_exc = '0;
	load_stim(ok);
	if(!ok)
	begin
		$display("could not read any operation from bench/fpu_stim.txt");
		end_run(1'b1);
	end
	else
	begin
		cycle_limit = 4 * stim_q.size() + 20;
		@(posedge arst_n);
		@(negedge clk);
		foreach(stim_q[k])
			run_op(stim_q[k], k);
		end_run(1'b0);
	end
end

initial
begin
	cycles = 0;
	wait(cycle_limit != 0);
	while(cycles < cycle_limit)
	begin
		@(posedge clk);
		cycles++;
	end
	$display("timeout: run still going after %0d cycles", cycles);
	end_run(1'b1);
end

endmodule

`default_nettype wire

//--- bench/fpu_checker.sv
`default_nettype none

module fpu_checker import fpu_op_pkg::*, fcsr_pkg::*; (
	input  logic        clk,
	input  logic        issue,
	input  logic        busy,
	input  fpu_op_t     op,
	input  word_t       exp_fpr,
	input  word_t       exp_gpr,
	input  logic [5:0]  exp_exc,
	input  logic        done,
	input  logic        fpr_we,
	input  word_t       fpr_wdata,
	input  logic        gpr_we,
	input  word_t       gpr_wdata,
	input  fpu_except_t except,
	output int          pass_cnt,
	output int          fail_cnt
);

timeunit 1ns;
timeprecision 100ps;

fpu_op_t    op_q;
word_t      fpr_q;
word_t      gpr_q;
logic [5:0] exc_q;
int         test_no = 0;  // ops accepted
int         done_no = 0;  // ops finished
int         wait_cyc = 0;
int         busy_cyc = 0;  // busy cycles seen for the open op
int         errs;

initial
begin
	pass_cnt = 0;
	fail_cnt = 0;
end

task mismatch(input string what, input word_t got, input word_t want);
	$display("error at %0d ns: test %0d %s %s is 0x%08h, expected 0x%08h",
		$time, test_no, op_q.name(), what, got, want);
	errs++;
endtask

task check_result;
	logic long_op;
	logic fpr_exp_we;
	logic gpr_exp_we;
	long_op    = op_q inside {FPU_OP_COND, FPU_OP_TRUNC, FPU_OP_ROUND, FPU_OP_CEIL,
		FPU_OP_FLOOR, FPU_OP_CVTW};
	fpr_exp_we = op_q inside {FPU_OP_MOV, FPU_OP_MTC, FPU_OP_NEG, FPU_OP_ABS, FPU_OP_TRUNC,
		FPU_OP_ROUND, FPU_OP_CEIL, FPU_OP_FLOOR, FPU_OP_CVTW};
	gpr_exp_we = op_q inside {FPU_OP_MFC, FPU_OP_CFC};
	errs = 0;
	if(wait_cyc != (long_op ? 2 : 1))
		mismatch("latency", 32'(wait_cyc), long_op ? 32'd2 : 32'd1);
	if(busy_cyc != (long_op ? 1 : 0))
		mismatch("busy cycles", 32'(busy_cyc), long_op ? 32'd1 : 32'd0);
	if(fpr_we != fpr_exp_we)
		mismatch("fpr_we", 32'(fpr_we), 32'(fpr_exp_we));
	else if(fpr_we && fpr_wdata != fpr_q)
		mismatch("fpr_wdata", fpr_wdata, fpr_q);
	if(gpr_we != gpr_exp_we)
		mismatch("gpr_we", 32'(gpr_we), 32'(gpr_exp_we));
	else if(gpr_we && gpr_wdata != gpr_q)
		mismatch("gpr_wdata", gpr_wdata, gpr_q);
	if(except != exc_q)
		mismatch("except", 32'(except), 32'(exc_q));
	if(errs == 0)
	begin
		$display("test %0d %s: ok", test_no, op_q.name());
		pass_cnt++;
	end
	else
	begin
		$display("test %0d %s: %0d mismatches", test_no, op_q.name(), errs);
		fail_cnt++;
	end
	done_no = test_no;
endtask

// expected values latched with the op
always @(posedge clk)
begin
	wait_cyc++;
	if(issue && !busy)
	begin
		op_q     = op;
		fpr_q    = exp_fpr;
		gpr_q    = exp_gpr;
		exc_q    = exp_exc;
		wait_cyc = 0;
		busy_cyc = 0;
		test_no++;
	end
end

always @(negedge clk)
begin
	if(busy && test_no != done_no)
		busy_cyc++;
	if(done && test_no == done_no)
	begin
		$display("done pulse at %0d ns with no operation outstanding", $time);
		fail_cnt++;
	end
	else if(done)
		check_result();
	else if(test_no != done_no && wait_cyc > 3)
	begin
		$display("test %0d %s: done never came, gave up after %0d cycles",
			test_no, op_q.name(), wait_cyc);
		fail_cnt++;
		done_no = test_no;
	end
end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int period_ns    = 10,
	parameter int reset_cycles = 3
) (
	output logic clk,
	output logic arst_n
);

timeunit 1ns;
timeprecision 100ps;

initial
begin
	clk = 1'b0;
	forever #(period_ns / 2) clk = ~clk;
end

initial
begin
	arst_n = 1'b0;
	repeat(reset_cycles) @(posedge clk);
	@(negedge clk);
	arst_n = 1'b1;  // release away from the active edge
end

endmodule

`default_nettype wire

//--- rtl/fpu_top.sv
`default_nettype none

module fpu_top import fpu_op_pkg::*, fcsr_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        issue,
	input  fpu_op_t     op,
	input  word_t       inst,
	input  word_t       fs_val,
	input  word_t       ft_val,
	input  word_t       gpr_val,
	output logic        done,
	output logic        fpr_we,
	output word_t       fpr_wdata,
	output logic        gpr_we,
	output word_t       gpr_wdata,
	output fpu_except_t except,
	output logic        busy
);

logic        ctc_we;
logic [4:0]  ctc_sel;
word_t       ctc_data;
logic        exc_we;
fpu_except_t exc;
logic        fcc_we;
logic [2:0]  fcc_sel;
logic        fcc_bit;
rm_t         rm;
fcc_t        fcc;
word_t       cfc_data;

fpu_ex ex_i(.*);

fcsr_regs fcsr_i(.*);

endmodule

`default_nettype wire

//--- rtl/fpu_ex.sv
`default_nettype none
`include "fpu_consts.svh"

module fpu_ex import fpu_op_pkg::*, fcsr_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        issue,
	input  fpu_op_t     op,
	input  word_t       inst,
	input  word_t       fs_val,
	input  word_t       ft_val,
	input  word_t       gpr_val,
	output logic        done,
	output logic        fpr_we,
	output word_t       fpr_wdata,
	output logic        gpr_we,
	output word_t       gpr_wdata,
	output fpu_except_t except,
	output logic        busy,
	output logic        ctc_we,
	output logic [4:0]  ctc_sel,
	output word_t       ctc_data,
	output logic        exc_we,
	output fpu_except_t exc,
	output logic        fcc_we,
	output logic [2:0]  fcc_sel,
	output logic        fcc_bit,
	input  rm_t         rm,
	input  fcc_t        fcc,
	input  word_t       cfc_data
);

function automatic logic [1:0] op_latency(input fpu_op_t o);
	case(o)
	FPU_OP_COND: op_latency = 2'(`FPU_LAT_COND);
	FPU_OP_TRUNC, FPU_OP_ROUND, FPU_OP_CEIL, FPU_OP_FLOOR, FPU_OP_CVTW:
		op_latency = 2'(`FPU_LAT_CVT);
	default: op_latency = 2'd1;
	endcase
endfunction

fpu_op_t     op_q;
word_t       inst_q, fs_q, ft_q, gpr_q;
logic [1:0]  cnt;
logic        last, accept, fs_nan;
logic        unordered, less, equal;
word_t       trunc_w, round_w, ceil_w, floor_w;
logic        invalid_trunc, invalid_round, invalid_ceil, invalid_floor;
logic        fpr_op, gpr_op, exc_op;
word_t       fpr_res, gpr_res;
fpu_except_t exc_res;

assign last   = (cnt == 2'd1);
assign busy   = (cnt != 2'd0) && (cnt != op_latency(op_q));  // past first cycle
assign accept = issue && !busy && (cnt == 2'd0 || last);

always_ff @(posedge clk or negedge arst_n)
begin
	if(!arst_n)
		cnt <= 2'd0;
	else if(accept)
		cnt <= op_latency(op);
	else if(cnt != 2'd0)
		cnt <= cnt - 2'd1;
end

always_ff @(posedge clk)
begin
	if(accept)
	begin
		op_q   <= op;
		inst_q <= inst;
		fs_q   <= fs_val;
		ft_q   <= ft_val;
		gpr_q  <= gpr_val;
	end
end

fp_compare compare_i(.a(fs_q), .b(ft_q), .unordered, .greater(), .less, .equal);

fp_to_int to_int_i(
	.value(fs_q),
	.trunc_w, .round_w, .ceil_w, .floor_w,
	.invalid_trunc, .invalid_round, .invalid_ceil, .invalid_floor
);

assign fs_nan = (fs_q == `FPU_QNAN_A) || (fs_q == `FPU_QNAN_B);
assign fpr_op = op_q inside {FPU_OP_MOV, FPU_OP_MTC, FPU_OP_NEG, FPU_OP_ABS, FPU_OP_TRUNC,
	FPU_OP_ROUND, FPU_OP_CEIL, FPU_OP_FLOOR, FPU_OP_CVTW};
assign exc_op = op_q inside {FPU_OP_NEG, FPU_OP_ABS, FPU_OP_TRUNC, FPU_OP_ROUND,
	FPU_OP_CEIL, FPU_OP_FLOOR, FPU_OP_CVTW};
assign gpr_op = op_q inside {FPU_OP_MFC, FPU_OP_CFC};

always_comb
begin
	fpr_res = fs_q;  // MOV
	gpr_res = '0;
	exc_res = '0;
	case(op_q)
	FPU_OP_MTC: fpr_res = gpr_q;
	FPU_OP_MFC: gpr_res = ft_q;
	FPU_OP_CFC: gpr_res = cfc_data;
	FPU_OP_NEG:
	begin
		exc_res.invalid = fs_nan;
		fpr_res = fs_nan ? fs_q : {~fs_q[31], fs_q[30:0]};
	end
	FPU_OP_ABS:
	begin
		exc_res.invalid = fs_nan;
		fpr_res = fs_nan ? fs_q : {1'b0, fs_q[30:0]};
	end
	FPU_OP_TRUNC: {exc_res.invalid, fpr_res} = {invalid_trunc, trunc_w};
	FPU_OP_ROUND: {exc_res.invalid, fpr_res} = {invalid_round, round_w};
	FPU_OP_CEIL:  {exc_res.invalid, fpr_res} = {invalid_ceil, ceil_w};
	FPU_OP_FLOOR: {exc_res.invalid, fpr_res} = {invalid_floor, floor_w};
	FPU_OP_CVTW:
	begin
		case(rm)
		RM_NEAREST: {exc_res.invalid, fpr_res} = {invalid_round, round_w};
		RM_ZERO:    {exc_res.invalid, fpr_res} = {invalid_trunc, trunc_w};
		RM_UP:      {exc_res.invalid, fpr_res} = {invalid_ceil, ceil_w};
		default:    {exc_res.invalid, fpr_res} = {invalid_floor, floor_w};
		endcase
	end
	FPU_OP_INVALID: exc_res.unimpl = 1'b1;
	default: ;
	endcase
end

// mask bits are unordered, less, equal
assign fcc_bit = |({unordered, less, equal} & {inst_q[0], inst_q[2], inst_q[1]});
assign fcc_sel = inst_q[10:8];
assign fcc_we  = last && (op_q == FPU_OP_COND) && (fcc[fcc_sel] != fcc_bit);  // only on change

assign ctc_we   = last && (op_q == FPU_OP_CTC);
assign ctc_sel  = inst_q[15:11];  // also the CFC read index
assign ctc_data = gpr_q;
assign exc_we   = last && exc_op;
assign exc      = exc_res;

always_ff @(posedge clk or negedge arst_n)
begin
	if(!arst_n)
	begin
		done   <= 1'b0;
		fpr_we <= 1'b0;
		gpr_we <= 1'b0;
	end
	else
	begin
		done   <= last;
		fpr_we <= last && fpr_op;
		gpr_we <= last && gpr_op;
	end
end

always_ff @(posedge clk)
begin
	if(last)
	begin
		fpr_wdata <= fpr_res;
		gpr_wdata <= gpr_res;
		except    <= exc_res;
	end
end

endmodule

`default_nettype wire

//--- rtl/fcsr_regs.sv
`default_nettype none
`include "fpu_consts.svh"

module fcsr_regs import fpu_op_pkg::*, fcsr_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        ctc_we,
	input  logic [4:0]  ctc_sel,
	input  word_t       ctc_data,
	input  logic        exc_we,
	input  fpu_except_t exc,
	input  logic        fcc_we,
	input  logic [2:0]  fcc_sel,
	input  logic        fcc_bit,
	output rm_t         rm,
	output fcc_t        fcc,
	output word_t       cfc_data
);

logic        fs;
fpu_except_t cause;
flags_t      enables;
flags_t      flags;

always_ff @(posedge clk or negedge arst_n)
begin
	if(!arst_n)
	begin
		fcc     <= '0;
		fs      <= 1'b0;
		cause   <= '0;
		enables <= '0;
		flags   <= '0;
		rm      <= RM_NEAREST;
	end
	else if(ctc_we)
	begin
		case(ctc_sel)
		5'(`FCSR_FCCR): fcc <= ctc_data[7:0];
		5'(`FCSR_FEXR):
		begin
			cause <= ctc_data[17:12];
			flags <= ctc_data[6:2];
		end
		5'(`FCSR_FENR):
		begin
			enables <= ctc_data[11:7];
			fs      <= ctc_data[2];
			rm      <= rm_t'(ctc_data[1:0]);
		end
		5'(`FCSR_FCSR):
		begin
			fcc     <= {ctc_data[31:25], ctc_data[23]};
			fs      <= ctc_data[24];
			cause   <= ctc_data[17:12];
			enables <= ctc_data[11:7];
			flags   <= ctc_data[6:2];
			rm      <= rm_t'(ctc_data[1:0]);
		end
		default: ;  // other indices ignored
		endcase
	end
	else if(exc_we)
	begin
		cause <= exc;
		flags <= flags | exc[4:0];  // sticky
	end
	else if(fcc_we)
		fcc[fcc_sel] <= fcc_bit;
end

always_comb
begin
	case(ctc_sel)
	5'(`FCSR_FCCR): cfc_data = {24'd0, fcc};
	5'(`FCSR_FEXR): cfc_data = {14'd0, cause, 5'd0, flags, 2'd0};
	5'(`FCSR_FENR): cfc_data = {20'd0, enables, 4'd0, fs, rm};
	5'(`FCSR_FCSR): cfc_data = {fcc[7:1], fs, fcc[0], 5'd0, cause, enables, flags, rm};
	default:        cfc_data = '0;
	endcase
end

endmodule

`default_nettype wire

//--- rtl/fp_to_int.sv
`default_nettype none

module fp_to_int import fpu_op_pkg::*; (
	input  word_t value,
	output word_t trunc_w,
	output word_t round_w,
	output word_t ceil_w,
	output word_t floor_w,
	output logic  invalid_trunc,
	output logic  invalid_round,
	output logic  invalid_ceil,
	output logic  invalid_floor
);

logic        sign;
logic [7:0]  exp;
logic [23:0] mant;
logic        special;
logic [5:0]  sh;
logic [63:0] fixed;
logic [31:0] int_part;
logic        half, sticky, frac;

// adds the rounding increment, range checks and applies the sign
function automatic logic [32:0] to_word(input logic neg, input logic bad,
		input logic [31:0] mag_in, input logic inc);
	logic [32:0] mag;
	logic        over;
	mag  = {1'b0, mag_in} + {32'd0, inc};
	over = neg ? (mag > 33'h080000000) : (mag > 33'h07fffffff);
	if(bad || over)
		to_word = {1'b1, 32'h7fffffff};
	else
		to_word = {1'b0, neg ? -mag[31:0] : mag[31:0]};
endfunction

assign sign    = value[31];
assign exp     = value[30:23];
assign mant    = {exp != 8'd0, value[22:0]};
assign special = exp >= 8'd159;  // nan, inf, |x| >= 2^32
assign sh      = 6'(exp - 8'd118);

// 32.32 fixed point of the magnitude
assign fixed    = (exp >= 8'd118) ? (64'(mant) << sh) : 64'd0;
assign int_part = fixed[63:32];
assign half     = fixed[31];
assign sticky   = (exp >= 8'd118) ? (|fixed[30:0]) : (|mant);
assign frac     = half | sticky;

assign {invalid_trunc, trunc_w} = to_word(sign, special, int_part, 1'b0);
assign {invalid_round, round_w} = to_word(sign, special, int_part,
	half & (sticky | int_part[0]));  // ties to even
assign {invalid_ceil, ceil_w}   = to_word(sign, special, int_part, ~sign & frac);
assign {invalid_floor, floor_w} = to_word(sign, special, int_part, sign & frac);

endmodule

`default_nettype wire

//--- rtl/fp_compare.sv
`default_nettype none

module fp_compare import fpu_op_pkg::*; (
	input  word_t a,
	input  word_t b,
	output logic  unordered,
	output logic  greater,
	output logic  less,
	output logic  equal
);

logic a_nan, b_nan;
logic both_zero;

assign a_nan     = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
assign b_nan     = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
assign both_zero = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);  // +0 == -0

assign unordered = a_nan | b_nan;
assign equal     = ~unordered & ((a == b) | both_zero);

always_comb
begin
	if(unordered || equal)
		less = 1'b0;
	else if(a[31] != b[31])
		less = a[31];  // zero pair already equal
	else if(a[31])
		less = b[30:0] < a[30:0];  // both negative
	else
		less = a[30:0] < b[30:0];
end

assign greater = ~unordered & ~equal & ~less;

endmodule

`default_nettype wire

//--- rtl/fcsr_pkg.sv
`default_nettype none

package fcsr_pkg;

typedef enum logic [1:0] {
	RM_NEAREST = 2'd0,
	RM_ZERO    = 2'd1,
	RM_UP      = 2'd2,
	RM_DOWN    = 2'd3
} rm_t;

// same bit order as the cause field
typedef struct packed {
	logic unimpl;
	logic invalid;
	logic divided_by_zero;
	logic overflow;
	logic underflow;
	logic inexact;
} fpu_except_t;

typedef logic [4:0] flags_t;  // flags and enables, no unimpl bit
typedef logic [7:0] fcc_t;

endpackage

`default_nettype wire

//--- rtl/fpu_op_pkg.sv
`default_nettype none
`include "fpu_consts.svh"

package fpu_op_pkg;

typedef logic [`FPU_WORD-1:0] word_t;

typedef enum logic [4:0] {
	FPU_OP_NOP     = 5'd0,
	FPU_OP_MOV     = 5'd1,
	FPU_OP_MTC     = 5'd2,
	FPU_OP_MFC     = 5'd3,
	FPU_OP_NEG     = 5'd4,
	FPU_OP_ABS     = 5'd5,
	FPU_OP_COND    = 5'd6,
	FPU_OP_TRUNC   = 5'd7,
	FPU_OP_ROUND   = 5'd8,
	FPU_OP_CEIL    = 5'd9,
	FPU_OP_FLOOR   = 5'd10,
	FPU_OP_CVTW    = 5'd11,  // direction from fcsr rm
	FPU_OP_CTC     = 5'd12,
	FPU_OP_CFC     = 5'd13,
	FPU_OP_INVALID = 5'd14
} fpu_op_t;

endpackage

`default_nettype wire

//--- rtl/fpu_consts.svh
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

`define FPU_WORD 32

// FCSR indices seen by CTC and CFC
`define FCSR_FCCR 25
`define FCSR_FEXR 26
`define FCSR_FENR 28
`define FCSR_FCSR 31

`define FPU_LAT_COND 2
`define FPU_LAT_CVT  2

`define FPU_QNAN_A 32'h7fffffff  // default nan patterns
`define FPU_QNAN_B 32'h7fbfffff

`endif
